// File: src/psg_pkg.sv
package psg_pkg;

	// ------------------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------------------
	localparam int NVOICE     = 4;
	localparam int VOICE_W    = 2;
	localparam int ACC_W      = 24;
	localparam int FREQ_W     = 16;
	localparam int WAVE_W     = 12;
	localparam int ENV_W      = 8;
	localparam int MIX_W      = 14;
	localparam int SAMPLE_W   = 16;
	localparam int CREDIT_MAX = 4;
	localparam int CREDIT_W   = 3;
	localparam int ADR_W      = 5;
	localparam int DATA_W     = 32;
	localparam int VOL_W      = 4;

	// ------------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------------
	// word offsets inside one voice block of four words
	localparam logic [1:0] REG_FREQ = 2'd0;
	localparam logic [1:0] REG_PW   = 2'd1;
	localparam logic [1:0] REG_CTRL = 2'd2;
	localparam logic [1:0] REG_ENV  = 2'd3;
	// master volume sits right after the last voice block
	localparam logic [ADR_W-1:0] REG_VOLUME = 5'd16;

	// waveform select codes, code 3 is silent
	localparam logic [1:0] WAVE_SAW   = 2'd0;
	localparam logic [1:0] WAVE_PULSE = 2'd1;
	localparam logic [1:0] WAVE_TRI   = 2'd2;

	// control word layout
	typedef struct packed {
		logic [22:0] rsvd2;
		logic        enable;
		logic        test;
		logic [1:0]  rsvd1;
		logic        gate;
		logic [1:0]  rsvd0;
		logic [1:0]  wave;
	} ctrl_word_t;

	// envelope word layout, one byte per step
	typedef struct packed {
		logic [ENV_W-1:0] relese;
		logic [ENV_W-1:0] sustain;
		logic [ENV_W-1:0] decay;
		logic [ENV_W-1:0] attack;
	} env_word_t;

	// same write data word seen as control or as envelope
	typedef union packed {
		ctrl_word_t ctrl;
		env_word_t  env;
	} reg_word_u;

	// settings of one voice
	typedef struct packed {
		logic [FREQ_W-1:0] freq;
		logic [WAVE_W-1:0] pw;
		logic [1:0]        wave;
		logic              gate;
		logic              test;
		logic              enable;
		logic [ENV_W-1:0]  attack;
		logic [ENV_W-1:0]  decay;
		logic [ENV_W-1:0]  sustain;
		logic [ENV_W-1:0]  relese;
	} voice_cfg_t;

	typedef enum logic [1:0] {
		ENV_IDLE,
		ENV_ATTACK,
		ENV_DECAY_SUSTAIN,
		ENV_RELEASE
	} env_state_e;

endpackage

// File: src/voice_regs.sv
`timescale 1ns/1ps

module voice_regs
	import psg_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              wr_i,
	input  logic [ADR_W-1:0]  adr_i,
	input  logic [DATA_W-1:0] dat_i,
	output voice_cfg_t        cfg_o [NVOICE],
	output logic [VOL_W-1:0]  volume_o
);

	// write data seen through both register views
	reg_word_u word;
	// voice block selected by the address
	logic [VOICE_W-1:0] sel;
	// address falls inside the voice blocks
	logic voice_hit;

	assign word = dat_i;
	assign sel = adr_i[VOICE_W+1:2];
	assign voice_hit = adr_i < ADR_W'(NVOICE * 4);

	// ------------------------------------------------------------------------
	// write decode
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < NVOICE; i++) begin
				cfg_o[i] <= '0;
			end
			volume_o <= '0;
		end else if (wr_i) begin
			if (voice_hit) begin
				// low two address bits pick the word inside the block
				case (adr_i[1:0])
				REG_FREQ: begin
					cfg_o[sel].freq <= dat_i[FREQ_W-1:0];
				end
				REG_PW: begin
					// only the low 12 bits compare against the wave
					cfg_o[sel].pw <= dat_i[WAVE_W-1:0];
				end
				REG_CTRL: begin
					cfg_o[sel].wave   <= word.ctrl.wave;
					cfg_o[sel].gate   <= word.ctrl.gate;
					cfg_o[sel].test   <= word.ctrl.test;
					cfg_o[sel].enable <= word.ctrl.enable;
				end
				REG_ENV: begin
					cfg_o[sel].attack  <= word.env.attack;
					cfg_o[sel].decay   <= word.env.decay;
					cfg_o[sel].sustain <= word.env.sustain;
					cfg_o[sel].relese  <= word.env.relese;
				end
				endcase
			end else if (adr_i == REG_VOLUME) begin
				volume_o <= dat_i[VOL_W-1:0];
			end
			// anything else above the voice blocks is dropped
		end
	end

endmodule

// File: src/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer
	import psg_pkg::*;
(
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               credit_i,
	output logic               iss_valid_o,
	output logic [VOICE_W-1:0] iss_voice_o
);

	// credits returned by the sink and not yet spent
	logic [CREDIT_W-1:0] credit_cnt;
	// frame in progress after its first cycle
	logic busy;
	// next voice to issue, wraps back to 0 at frame end
	logic [VOICE_W-1:0] voice_cnt;
	logic start;
	logic credit_ok;

	// a frame starts only with credit in hand and no frame being issued
	assign start = (credit_cnt != '0) && !busy;
	// a credit beyond the limit is a sink error and is not counted
	assign credit_ok = credit_i && (credit_cnt != CREDIT_W'(CREDIT_MAX));

	// voice 0 goes out in the start cycle itself
	assign iss_valid_o = start || busy;
	assign iss_voice_o = voice_cnt;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			credit_cnt <= '0;
			busy       <= 1'b0;
			voice_cnt  <= '0;
		end else begin
			// return and spend can land in the same cycle
			credit_cnt <= credit_cnt + CREDIT_W'(credit_ok) - CREDIT_W'(start);
			if (start) begin
				busy      <= 1'b1;
				voice_cnt <= VOICE_W'(1);
			end else if (busy) begin
				voice_cnt <= voice_cnt + 1'b1;
				// last voice out, free for a new frame next cycle
				if (voice_cnt == VOICE_W'(NVOICE - 1)) begin
					busy <= 1'b0;
				end
			end
		end
	end

endmodule

// File: src/phase_stage.sv
`timescale 1ns/1ps

module phase_stage
	import psg_pkg::*;
(
	input  logic               clk_i,
	input  logic               rst_i,
	input  voice_cfg_t         cfg_i [NVOICE],
	input  logic               iss_valid_i,
	input  logic [VOICE_W-1:0] iss_voice_i,
	output logic               ph_valid_o,
	output logic [VOICE_W-1:0] ph_voice_o,
	output logic [WAVE_W-1:0]  ph_wave_o
);

	// one phase accumulator per voice
	logic [ACC_W-1:0] acc [NVOICE];
	// accumulator of the voice being issued, before its update
	logic [ACC_W-1:0] cur;
	logic [WAVE_W-1:0] top;
	logic [WAVE_W-2:0] fold;
	logic [WAVE_W-1:0] wave;
	voice_cfg_t cfg;

	assign cfg = cfg_i[iss_voice_i];
	assign cur = acc[iss_voice_i];
	// sawtooth is simply the top of the accumulator
	assign top = cur[ACC_W-1 -: WAVE_W];
	// second half of the period runs the ramp backwards
	assign fold = cur[ACC_W-1] ? ~top[WAVE_W-2:0] : top[WAVE_W-2:0];

	// ------------------------------------------------------------------------
	// waveform select
	// ------------------------------------------------------------------------
	always_comb begin
		case (cfg.wave)
		WAVE_SAW:   wave = top;
		WAVE_PULSE: wave = (top < cfg.pw) ? '1 : '0;
		// folded ramp doubled back to full scale
		WAVE_TRI:   wave = {fold, 1'b0};
		default:    wave = '0;
		endcase
	end

	// accumulator step, test parks the oscillator at zero
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < NVOICE; i++) begin
				acc[i] <= '0;
			end
		end else if (iss_valid_i) begin
			acc[iss_voice_i] <= cfg.test ? '0 : cur + ACC_W'(cfg.freq);
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ph_valid_o <= 1'b0;
		end else begin
			ph_valid_o <= iss_valid_i;
		end
	end

	// item payload
	always_ff @(posedge clk_i) begin
		if (iss_valid_i) begin
			ph_voice_o <= iss_voice_i;
			ph_wave_o  <= wave;
		end
	end

endmodule

// File: src/envelope_stage.sv
`timescale 1ns/1ps

module envelope_stage
	import psg_pkg::*;
(
	input  logic               clk_i,
	input  logic               rst_i,
	input  voice_cfg_t         cfg_i [NVOICE],
	input  logic               ph_valid_i,
	input  logic [VOICE_W-1:0] ph_voice_i,
	input  logic [WAVE_W-1:0]  ph_wave_i,
	output logic               sh_valid_o,
	output logic [VOICE_W-1:0] sh_voice_o,
	output logic [WAVE_W-1:0]  sh_value_o
);

	// per voice envelope state and level
	env_state_e state [NVOICE];
	logic [ENV_W-1:0] level [NVOICE];
	voice_cfg_t cfg;
	// state after the gate has had its say
	env_state_e cur_st;
	env_state_e nxt_st;
	logic [ENV_W-1:0] cur_lvl;
	logic [ENV_W-1:0] nxt_lvl;
	// one extra bit to catch attack overflow
	logic [ENV_W:0] att_sum;
	logic [WAVE_W+ENV_W-1:0] product;

	assign cfg = cfg_i[ph_voice_i];
	assign cur_lvl = level[ph_voice_i];
	assign att_sum = {1'b0, cur_lvl} + {1'b0, cfg.attack};

	// gate on restarts the attack, gate off forces release
	always_comb begin
		cur_st = state[ph_voice_i];
		if (cfg.gate && (cur_st == ENV_IDLE || cur_st == ENV_RELEASE)) begin
			cur_st = ENV_ATTACK;
		end else if (!cfg.gate && cur_st != ENV_IDLE) begin
			cur_st = ENV_RELEASE;
		end
	end

	// ------------------------------------------------------------------------
	// level step, one per frame for this voice
	// ------------------------------------------------------------------------
	always_comb begin
		nxt_st  = cur_st;
		nxt_lvl = cur_lvl;
		case (cur_st)
		ENV_ATTACK: begin
			// saturate at full scale and move on to decay
			if (att_sum >= {1'b0, {ENV_W{1'b1}}}) begin
				nxt_lvl = '1;
				nxt_st  = ENV_DECAY_SUSTAIN;
			end else begin
				nxt_lvl = att_sum[ENV_W-1:0];
			end
		end
		ENV_DECAY_SUSTAIN: begin
			// fall towards sustain, never below it
			if (cur_lvl > cfg.sustain) begin
				if (cur_lvl - cfg.sustain > cfg.decay) begin
					nxt_lvl = cur_lvl - cfg.decay;
				end else begin
					nxt_lvl = cfg.sustain;
				end
			end
		end
		ENV_RELEASE: begin
			if (cur_lvl > cfg.relese) begin
				nxt_lvl = cur_lvl - cfg.relese;
			end else begin
				nxt_lvl = '0;
				nxt_st  = ENV_IDLE;
			end
		end
		default: begin
			nxt_lvl = cur_lvl;
		end
		endcase
	end

	// shaped value uses the level of this very step
	assign product = ph_wave_i * nxt_lvl;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < NVOICE; i++) begin
				state[i] <= ENV_IDLE;
				level[i] <= '0;
			end
			sh_valid_o <= 1'b0;
		end else begin
			sh_valid_o <= ph_valid_i;
			if (ph_valid_i) begin
				state[ph_voice_i] <= nxt_st;
				level[ph_voice_i] <= nxt_lvl;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (ph_valid_i) begin
			sh_voice_o <= ph_voice_i;
			// drop the 8 fraction bits of the level
			sh_value_o <= product[WAVE_W+ENV_W-1:ENV_W];
		end
	end

endmodule

// File: src/mix_stage.sv
`timescale 1ns/1ps

module mix_stage
	import psg_pkg::*;
(
	input  logic                clk_i,
	input  logic                rst_i,
	input  voice_cfg_t          cfg_i [NVOICE],
	input  logic [VOL_W-1:0]    volume_i,
	input  logic                sh_valid_i,
	input  logic [VOICE_W-1:0]  sh_voice_i,
	input  logic [WAVE_W-1:0]   sh_value_i,
	output logic                sample_valid_o,
	output logic [SAMPLE_W-1:0] aud_o
);

	// running sum over the voices of one frame
	logic [MIX_W-1:0] sum_q;
	logic [MIX_W-1:0] sum_d;
	// contribution of this item, zero if the voice is muted
	logic [WAVE_W-1:0] add;
	logic [MIX_W+VOL_W-1:0] scaled;
	logic last;

	assign add = cfg_i[sh_voice_i].enable ? sh_value_i : '0;
	// voice 0 opens a new frame sum
	assign sum_d = (sh_voice_i == '0) ? MIX_W'(add) : sum_q + MIX_W'(add);
	assign last = sh_voice_i == VOICE_W'(NVOICE - 1);
	// master volume 0..15, then two bits down to fit the sample
	assign scaled = sum_d * volume_i;

	always_ff @(posedge clk_i) begin
		if (sh_valid_i) begin
			sum_q <= sum_d;
		end
	end

	// ------------------------------------------------------------------------
	// sample output
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sample_valid_o <= 1'b0;
			aud_o          <= '0;
		end else begin
			sample_valid_o <= sh_valid_i && last;
			// aud_o keeps the last sample between pulses
			if (sh_valid_i && last) begin
				aud_o <= scaled[MIX_W+VOL_W-1:2];
			end
		end
	end

endmodule

// File: src/psg_top.sv
`timescale 1ns/1ps

module psg_top
	import psg_pkg::*;
(
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                wr_i,
	input  logic [ADR_W-1:0]    adr_i,
	input  logic [DATA_W-1:0]   dat_i,
	input  logic                credit_i,
	output logic                sample_valid_o,
	output logic [SAMPLE_W-1:0] aud_o
);

	// register file outputs
	voice_cfg_t cfg [NVOICE];
	logic [VOL_W-1:0] volume;

	// ------------------------------------------------------------------------
	// voice stream between the stages
	// ------------------------------------------------------------------------
	logic               iss_valid;
	logic [VOICE_W-1:0] iss_voice;
	logic               ph_valid;
	logic [VOICE_W-1:0] ph_voice;
	logic [WAVE_W-1:0]  ph_wave;
	logic               sh_valid;
	logic [VOICE_W-1:0] sh_voice;
	logic [WAVE_W-1:0]  sh_value;

	voice_regs u_regs (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.wr_i     (wr_i),
		.adr_i    (adr_i),
		.dat_i    (dat_i),
		.cfg_o    (cfg),
		.volume_o (volume)
	);

	// frame start and voice issue
	frame_sequencer u_seq (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.credit_i    (credit_i),
		.iss_valid_o (iss_valid),
		.iss_voice_o (iss_voice)
	);

	// oscillators
	phase_stage u_phase (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.cfg_i       (cfg),
		.iss_valid_i (iss_valid),
		.iss_voice_i (iss_voice),
		.ph_valid_o  (ph_valid),
		.ph_voice_o  (ph_voice),
		.ph_wave_o   (ph_wave)
	);

	// ADSR and shaping
	envelope_stage u_env (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.cfg_i      (cfg),
		.ph_valid_i (ph_valid),
		.ph_voice_i (ph_voice),
		.ph_wave_i  (ph_wave),
		.sh_valid_o (sh_valid),
		.sh_voice_o (sh_voice),
		.sh_value_o (sh_value)
	);

	// voice sum and master volume
	mix_stage u_mix (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.cfg_i          (cfg),
		.volume_i       (volume),
		.sh_valid_i     (sh_valid),
		.sh_voice_i     (sh_voice),
		.sh_value_i     (sh_value),
		.sample_valid_o (sample_valid_o),
		.aud_o          (aud_o)
	);

endmodule

// File: verif/psg_checker.sv
`timescale 1ns/1ps

module psg_checker
	import psg_pkg::*;
(
	input logic               clk_i,
	input logic               rst_i,
	input logic               credit_i,
	input logic               iss_valid_i,
	input logic [VOICE_W-1:0] iss_voice_i,
	input logic               sample_valid_i
);

	// frame starts, delayed once per cycle up to the sample latency
	logic [5:0] start_d;
	logic frame_start;
	// running totals since reset
	int unsigned credit_cnt;
	int unsigned sample_cnt;
	// failed assertions, read by the testbench at the end of the run
	int unsigned fail_cnt = 0;

	// voice 0 is only ever issued in the cycle a frame starts
	assign frame_start = iss_valid_i && (iss_voice_i == '0);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			start_d    <= '0;
			credit_cnt <= 0;
			sample_cnt <= 0;
		end else begin
			start_d    <= {start_d[4:0], frame_start};
			credit_cnt <= credit_cnt + credit_i;
			sample_cnt <= sample_cnt + sample_valid_i;
		end
	end

	// ------------------------------------------------------------------------
	// properties
	// ------------------------------------------------------------------------
	// output quiet while reset is held and in the first cycle after it
	reset_quiet: assert property (@(posedge clk_i) $past(rst_i) |-> !sample_valid_i)
		else begin
			fail_cnt++;
			$error("sample_valid_o high during reset or right after it");
		end

	// one credit buys at most one sample
	credit_bound: assert property (@(posedge clk_i) disable iff (rst_i)
		sample_cnt <= credit_cnt)
		else begin
			fail_cnt++;
			$error("more samples emitted than credits returned");
		end

	// fixed six cycle latency, in both directions
	sample_latency: assert property (@(posedge clk_i) disable iff (rst_i)
		sample_valid_i == start_d[5])
		else begin
			fail_cnt++;
			$error("sample_valid_o not exactly six cycles after a frame start");
		end

endmodule

// File: verif/psg_tb.sv
`timescale 1ns/1ps

module psg_tb
	import psg_pkg::*;
();

	localparam int CLK_NS = 40;
	// frames over all tests for the watchdog
	localparam int TOTAL_FRAMES = 127;
	localparam int WATCHDOG_NS = (TOTAL_FRAMES * 8 + 1500) * CLK_NS;
	// envelope states of the model
	localparam int ST_IDLE = 0;
	localparam int ST_ATT  = 1;
	localparam int ST_DS   = 2;
	localparam int ST_REL  = 3;

	logic clk;
	logic rst;
	logic wr;
	logic [ADR_W-1:0] adr;
	logic [DATA_W-1:0] dat;
	logic credit;
	logic sample_valid;
	logic [SAMPLE_W-1:0] aud;
	logic [SAMPLE_W-1:0] exp_aud;

	integer seed;
	string test_name;
	int credits_given;
	int n_samples;
	int test_first;
	int err_cnt;
	int test_err;
	int tests_run;
	int chk_mark;

	// model register mirror
	int m_freq [NVOICE];
	int m_pw [NVOICE];
	int m_wave [NVOICE];
	int m_gate [NVOICE];
	int m_test [NVOICE];
	int m_en [NVOICE];
	int m_att [NVOICE];
	int m_dec [NVOICE];
	int m_sus [NVOICE];
	int m_rel [NVOICE];
	int m_vol;
	// model oscillator and envelope state
	int m_acc [NVOICE];
	int m_lvl [NVOICE];
	int m_st [NVOICE];

	psg_top UUT (
		.clk_i          (clk),
		.rst_i          (rst),
		.wr_i           (wr),
		.adr_i          (adr),
		.dat_i          (dat),
		.credit_i       (credit),
		.sample_valid_o (sample_valid),
		.aud_o          (aud)
	);

	bind psg_top psg_checker u_chk (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.credit_i       (credit_i),
		.iss_valid_i    (iss_valid),
		.iss_voice_i    (iss_voice),
		.sample_valid_i (sample_valid_o)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	// wave from the accumulator before this frame's step
	function automatic int wave_of(input int v);
		int top;
		int tri_v;
		top = m_acc[v] / 4096;
		case (m_wave[v])
		0: return top;
		1: return (top < m_pw[v]) ? 4095 : 0;
		2: begin
			tri_v = top % 2048;
			// falling half once the msb is set
			if (m_acc[v] >= 'h80_0000)
				tri_v = 2047 - tri_v;
			return tri_v * 2;
		end
		default: return 0;
		endcase
	endfunction

	function automatic void env_step(input int v);
		if (m_gate[v] != 0 && (m_st[v] == ST_IDLE || m_st[v] == ST_REL)) begin
			m_st[v] = ST_ATT;
		end else if (m_gate[v] == 0 && m_st[v] != ST_IDLE) begin
			m_st[v] = ST_REL;
		end
		case (m_st[v])
		ST_ATT: begin
			m_lvl[v] = m_lvl[v] + m_att[v];
			if (m_lvl[v] >= 255) begin
				m_lvl[v] = 255;
				m_st[v] = ST_DS;
			end
		end
		ST_DS: begin
			// sustain is a floor and a level already below it holds
			if (m_lvl[v] > m_sus[v]) begin
				m_lvl[v] = m_lvl[v] - m_dec[v];
				if (m_lvl[v] < m_sus[v])
					m_lvl[v] = m_sus[v];
			end
		end
		ST_REL: begin
			m_lvl[v] = m_lvl[v] - m_rel[v];
			if (m_lvl[v] <= 0) begin
				m_lvl[v] = 0;
				m_st[v] = ST_IDLE;
			end
		end
		default: begin
		end
		endcase
	endfunction

	// one whole frame, voices 0 to 3 in order
	function automatic int next_sample();
		int sum;
		int w;
		sum = 0;
		for (int v = 0; v < NVOICE; v++) begin
			w = wave_of(v);
			m_acc[v] = (m_test[v] != 0) ? 0 : (m_acc[v] + m_freq[v]) % 'h100_0000;
			env_step(v);
			if (m_en[v] != 0)
				sum = sum + (w * m_lvl[v]) / 256;
		end
		return (sum * m_vol) / 4;
	endfunction

	// every sample is compared against the model
	// aud_o holds the last sample between pulses and is zero before the first
	always @(posedge clk) begin
		if (!rst && sample_valid) begin
			exp_aud = SAMPLE_W'(next_sample());
			n_samples++;
			sample_match: assert (aud == exp_aud) else begin
				$display("[FAIL] %s: expected %0d, actual %0d", test_name, exp_aud, aud);
				err_cnt++;
				test_err++;
			end
		end else if (!rst) begin
			aud_hold: assert (aud == exp_aud) else begin
				$display("[FAIL] %s: held aud_o expected %0d, actual %0d",
					test_name, exp_aud, aud);
				err_cnt++;
				test_err++;
			end
		end
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	// host write mirrored into the model
	task automatic write_reg(input logic [ADR_W-1:0] a, input logic [DATA_W-1:0] d);
		int v;
		v = int'(a[ADR_W-1:2]);
		wr = 1'b1;
		adr = a;
		dat = d;
		@(posedge clk);
		#1;
		wr = 1'b0;
		if (a < NVOICE * 4) begin
			case (a[1:0])
			2'd0: m_freq[v] = int'(d[15:0]);
			2'd1: m_pw[v] = int'(d[11:0]);
			2'd2: begin
				m_wave[v] = int'(d[1:0]);
				m_gate[v] = int'(d[4]);
				m_test[v] = int'(d[7]);
				m_en[v] = int'(d[8]);
			end
			default: begin
				m_att[v] = int'(d[7:0]);
				m_dec[v] = int'(d[15:8]);
				m_sus[v] = int'(d[23:16]);
				m_rel[v] = int'(d[31:24]);
			end
			endcase
		end else if (a == REG_VOLUME) begin
			m_vol = int'(d[3:0]);
		end
	endtask

	// return n credits with at most CREDIT_MAX outstanding and then drain
	task automatic run_frames(input int n, input bit random_gaps);
		int target;
		int pause;
		target = credits_given + n;
		while (credits_given < target) begin
			if (random_gaps && ($random(seed) & 15) == 0) begin
				pause = ($random(seed) & 15) + 1;
				repeat (pause) @(posedge clk);
				#1;
			end
			if (credits_given - n_samples < CREDIT_MAX &&
			    (!random_gaps || ($random(seed) & 1) != 0)) begin
				credit = 1'b1;
				credits_given++;
			end
			@(posedge clk);
			#1;
			credit = 1'b0;
		end
		while (n_samples < credits_given) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err = 0;
		test_first = n_samples;
		chk_mark = UUT.u_chk.fail_cnt;
	endtask

	task automatic end_test();
		int chk_new;
		chk_new = UUT.u_chk.fail_cnt - chk_mark;
		tests_run++;
		if (test_err == 0 && chk_new == 0)
			$display("%s: ok, %0d samples", test_name, n_samples - test_first);
		else
			$display("%s: failed, %0d wrong values, %0d assertion failures",
				test_name, test_err, chk_new);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns with %0d of %0d samples seen",
			WATCHDOG_NS, n_samples, credits_given);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		seed = 32'hf63505ea;
		clk = 1'b0;
		rst = 1'b1;
		wr = 1'b0;
		adr = '0;
		dat = '0;
		credit = 1'b0;
		exp_aud = '0;
		credits_given = 0;
		n_samples = 0;
		err_cnt = 0;
		tests_run = 0;
		m_vol = 0;
		for (int v = 0; v < NVOICE; v++) begin
			m_freq[v] = 0;
			m_pw[v] = 0;
			m_wave[v] = 0;
			m_gate[v] = 0;
			m_test[v] = 0;
			m_en[v] = 0;
			m_att[v] = 0;
			m_dec[v] = 0;
			m_sus[v] = 0;
			m_rel[v] = 0;
			m_acc[v] = 0;
			m_lvl[v] = 0;
			m_st[v] = ST_IDLE;
		end
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// nothing may come out before a credit
		// voice 0 runs enabled at full volume but is never gated
		begin_test("idle_silence");
		write_reg(5'd0, 32'h0000_7a31);
		write_reg(5'd2, 32'h0000_0100);
		write_reg(REG_VOLUME, 32'h0000_000f);
		repeat (20) @(posedge clk);
		#1;
		no_early_sample: assert (n_samples == 0) else begin
			$display("a sample appeared before any credit was returned");
			err_cnt++;
			test_err++;
		end
		run_frames(4, 1'b0);
		end_test();

		// voice 0 sawtooth with full envelope from the first frame
		begin_test("saw_voice0");
		write_reg(5'd2, 32'h0000_0080);
		run_frames(1, 1'b0);
		write_reg(5'd0, 32'h0000_7a31);
		write_reg(5'd3, 32'h00ff_00ff);
		write_reg(5'd2, 32'h0000_0110);
		write_reg(REG_VOLUME, 32'h0000_000f);
		run_frames(16, 1'b0);
		end_test();

		// voice 1 pulse with a narrow width so the edge falls inside the run
		begin_test("pulse_voice1");
		write_reg(5'd2, 32'h0000_0000);
		write_reg(5'd4, 32'h0000_ffff);
		write_reg(5'd5, 32'h0000_0060);
		write_reg(5'd7, 32'h00ff_00ff);
		write_reg(5'd6, 32'h0000_0111);
		run_frames(16, 1'b0);
		end_test();

		// test bit parks the wave at 4095 so the output follows the level
		begin_test("adsr_voice2");
		write_reg(5'd6, 32'h0000_0000);
		write_reg(5'd9, 32'h0000_0fff);
		write_reg(5'd11, 32'h1e64_1428);
		write_reg(5'd10, 32'h0000_0191);
		run_frames(20, 1'b0);
		write_reg(5'd10, 32'h0000_0181);
		run_frames(12, 1'b0);
		end_test();

		// voice 3 gated but muted while the volume steps down
		begin_test("mix_volume");
		write_reg(5'd10, 32'h0000_0000);
		write_reg(5'd2, 32'h0000_0110);
		write_reg(5'd12, 32'h0000_5555);
		write_reg(5'd15, 32'h00ff_00ff);
		write_reg(5'd14, 32'h0000_0012);
		write_reg(5'd31, 32'hdead_beef);
		run_frames(6, 1'b0);
		write_reg(REG_VOLUME, 32'h0000_0007);
		run_frames(6, 1'b0);
		write_reg(REG_VOLUME, 32'h0000_0003);
		run_frames(6, 1'b0);
		end_test();

		begin_test("random_credits");
		write_reg(5'd14, 32'h0000_0112);
		run_frames(40, 1'b1);
		repeat (20) @(posedge clk);
		#1;
		sample_count: assert (n_samples == credits_given) else begin
			$display("[FAIL] %s: expected %0d, actual %0d",
				test_name, credits_given, n_samples);
			err_cnt++;
			test_err++;
		end
		end_test();

		$display("tests %0d, samples %0d, wrong values %0d, assertion failures %0d",
			tests_run, n_samples, err_cnt, UUT.u_chk.fail_cnt);
		if (err_cnt == 0 && UUT.u_chk.fail_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: src.f
src/psg_pkg.sv
src/voice_regs.sv
src/frame_sequencer.sv
src/phase_stage.sv
src/envelope_stage.sv
src/mix_stage.sv
src/psg_top.sv
verif/psg_checker.sv
verif/psg_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= psg_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
